/* dv/busTb.sv */
// Directed testbench with clock, reset, test tasks, compare tasks, reference memory and watchdog
`timescale 1ns/100ps
`include "bus_macros.svh"

module busTb import busPkg::*; ();

  localparam int PERIOD = 40;
  // Accesses per test, in order: full words, partial masks, wait states, CPU hold, random
  localparam int ACCESSES = 16 + 11 + 16 + 3 + 56;
  // Worst case per access is 2 + WAIT_MAX cycles plus a few idle cycles around it
  localparam int WATCHDOG_CYCLES = ACCESSES * (2 + `WAIT_MAX + 4) + 200;

  logic     HCLK;
  logic     rstN;
  cpuReq    req;
  logic     CPUBusy;
  logic     cfgWrite;
  waitCount cfgWaitStates;
  logic     BusStall;
  logic     BusCommitted;
  xlenData  FetchBuffer;
  waitCount cfgReadback;

  // Reference copy of the RAM contents, updated as each write completes
  xlenData  refMem [`RAM_WORDS];
  // Word the fetch buffer must keep until the next read completes
  xlenData  lastRead;
  logic     readDone;
  waitCount curWait;
  int       errorCount;
  int       checkCount;
  int       assertCount;
  integer   seed;

  busTop u_dut (.*);

  initial begin
    HCLK = 1'b0;
    forever #(PERIOD/2) HCLK = ~HCLK;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic checkData(string name, xlenData got, xlenData exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkWait(string name, waitCount got, waitCount exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkCycles(string name, int got, int exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////
  // Model and drivers
  ////////////////////

  // Lanes with a set mask bit take the new byte, the others keep the old one
  function automatic xlenData mergeBytes(xlenData old, xlenData wdata, byteMask mask);
    xlenData result;
    result = old;
    for (int i = 0; i < `XLEN/8; i++) begin
      if (mask[i]) begin
        result[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Fill pattern that changes with every bit of the word index
  function automatic xlenData fillWord(int word);
    return 32'hC3A5_0000 ^ (xlenData'(word) * 32'h0001_0101);
  endfunction

  // Counts cycles from the request up to and including the one that completes it
  task automatic waitComplete(output int cycles);
    cycles = 1;
    #(PERIOD/4);
    while (BusStall) begin
      @(negedge HCLK);
      #(PERIOD/4);
      cycles++;
    end
    @(posedge HCLK);
    @(negedge HCLK);
    req.rw = RW_NONE;
  endtask

  task automatic runAccess(busRw kind, int word, byteMask mask, xlenData wdata);
    int cycles;
    @(negedge HCLK);
    req = '{rw: kind, addr: busAddr'(word << 2), mask: mask, wdata: wdata};
    waitComplete(cycles);
    checkCycles("stall length", cycles, 2 + curWait);
    if (kind == RW_WRITE) begin
      refMem[word] = mergeBytes(refMem[word], wdata, mask);
      // A write leaves the last read word in the fetch buffer
      if (readDone) begin
        checkData("FetchBuffer", FetchBuffer, lastRead);
      end
    end else begin
      checkData("FetchBuffer", FetchBuffer, refMem[word]);
      lastRead = refMem[word];
      readDone = 1'b1;
    end
  endtask

  // The new count shows on readback one edge after the write pulse
  task automatic setWait(waitCount value);
    @(negedge HCLK);
    cfgWrite = 1'b1;
    cfgWaitStates = value;
    @(negedge HCLK);
    cfgWrite = 1'b0;
    curWait = (value > waitCount'(`WAIT_MAX)) ? waitCount'(`WAIT_MAX) : value;
    checkWait("cfgReadback", cfgReadback, curWait);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic testReset();
    checkFlag("BusStall", BusStall, 1'b0);
    checkFlag("BusCommitted", BusCommitted, 1'b0);
    checkWait("cfgReadback", cfgReadback, 3'd0);
  endtask

  task automatic testFullWords();
    for (int i = 0; i < 8; i++) runAccess(RW_WRITE, i, '1, fillWord(i));
    for (int i = 0; i < 8; i++) runAccess(RW_READ, i, '0, '0);
  endtask

  task automatic testPartial();
    byteMask masks [5] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0101};
    runAccess(RW_WRITE, 8, '1, fillWord(8));
    foreach (masks[i]) begin
      runAccess(RW_WRITE, 8, masks[i], 32'h1122_3344 + 32'h1111_1111 * i);
      runAccess(RW_READ, 8, '0, '0);
    end
  endtask

  task automatic testWaitStates();
    for (int w = 0; w <= 7; w++) begin
      setWait(waitCount'(w));
      runAccess(RW_WRITE, 16 + w, '1, ~fillWord(16 + w));
      runAccess(RW_READ, 16 + w, '0, '0);
    end
  endtask

  // A busy CPU parks the FSM in CPU_HOLD and the next request has to wait
  task automatic testCpuHold();
    int cycles;
    setWait(3'd2);
    CPUBusy = 1'b1;
    runAccess(RW_READ, 5, '0, '0);
    req = '{rw: RW_WRITE, addr: busAddr'(7 << 2), mask: '1, wdata: 32'h600D_F00D};
    repeat (3) begin
      #(PERIOD/4);
      checkFlag("BusCommitted", BusCommitted, 1'b1);
      checkFlag("BusStall", BusStall, 1'b0);
      @(negedge HCLK);
    end
    CPUBusy = 1'b0;
    @(negedge HCLK);
    waitComplete(cycles);
    checkCycles("held stall length", cycles, 2 + curWait);
    refMem[7] = 32'h600D_F00D;
    runAccess(RW_READ, 7, '0, '0);
  endtask

  task automatic testRandom();
    int word;
    for (int i = 32; i < 48; i++) runAccess(RW_WRITE, i, '1, $random(seed));
    for (int n = 0; n < 40; n++) begin
      if (($random(seed) & 3) == 0) begin
        setWait(waitCount'($random(seed)));
      end
      word = 32 + ($random(seed) & 15);
      runAccess(($random(seed) & 1) ? RW_WRITE : RW_READ, word,
                byteMask'($random(seed)), $random(seed));
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed = 53396;
    errorCount = 0;
    checkCount = 0;
    curWait = '0;
    readDone = 1'b0;
    lastRead = '0;
    rstN = 1'b0;
    req = '0;
    CPUBusy = 1'b0;
    cfgWrite = 1'b0;
    cfgWaitStates = '0;
    repeat (4) @(negedge HCLK);
    rstN = 1'b1;
    testReset();
    testFullWords();
    testPartial();
    testWaitStates();
    testCpuHold();
    testRandom();
    @(negedge HCLK);
    assertCount = u_dut.uBusAssert.assertErrors;
    $display("Summary: %0d checks, %0d check errors, %0d assertion errors",
             checkCount, errorCount, assertCount);
    if (errorCount == 0 && assertCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Ends a run that stopped making progress
  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

/* dv/bus_assert.sv */
// Bound assertions for stall and AHB-Lite transfer rules on the bus top level
`timescale 1ns/100ps

module busAssert import busPkg::*; (
  input logic     HCLK,
  input logic     rstN,
  input cpuReq    req,
  input ahbMaster bus,
  input logic     HREADY,
  input logic     BusStall,
  input logic     BusCommitted
);

  // Failure count read by the testbench summary
  int assertErrors = 0;

  // A stall needs a pending request or a data phase still waiting on HREADY
  stallHasCause: assert property (@(posedge HCLK) disable iff (!rstN)
    BusStall |-> (req.rw != RW_NONE) || !HREADY)
    else begin
      assertErrors++;
      $error("BusStall high with no request and no open data phase");
    end

  // An address goes out only from idle with the slave ready, and never twice in a row
  nonseqFromIdle: assert property (@(posedge HCLK) disable iff (!rstN)
    (bus.htrans == HTRANS_NONSEQ) |->
      (!BusCommitted && HREADY) ##1 (bus.htrans != HTRANS_NONSEQ))
    else begin
      assertErrors++;
      $error("NONSEQ issued while the FSM was not idle");
    end

  committedAfterReset: assert property (@(posedge HCLK) $rose(rstN) |-> !BusCommitted)
    else begin
      assertErrors++;
      $error("BusCommitted high right after reset");
    end

endmodule

bind busTop busAssert uBusAssert (
  .HCLK         (HCLK),
  .rstN         (rstN),
  .req          (req),
  .bus          (bus),
  .HREADY       (HREADY),
  .BusStall     (BusStall),
  .BusCommitted (BusCommitted)
);

/* flist.f */
+incdir+hdl
hdl/busPkg.sv
hdl/busFsm.sv
hdl/ahbInterface.sv
hdl/waitCfg.sv
hdl/ahbRam.sv
hdl/busTop.sv
dv/bus_assert.sv
dv/busTb.sv

/* hdl/ahbInterface.sv */
// AHB-Lite master data path with fetch buffer, delayed write data and strobes, and bus FSM
`timescale 1ns/100ps

module ahbInterface import busPkg::*; (
  input  logic     HCLK,
  input  logic     rstN,
  input  logic     HREADY,
  input  xlenData  HRDATA,
  input  cpuReq    req,
  input  logic     CPUBusy,
  output ahbMaster bus,
  output logic     BusStall,
  output logic     BusCommitted,
  output xlenData  FetchBuffer
);

  htrans   hTrans;
  logic    hWrite;
  logic    captureEn;
  xlenData hwdataQ;
  byteMask hwstrbQ;

  ////////////////////
  // Write path
  ////////////////////

  // AHB wants write data and strobes one cycle after the address
  // Loading only on NONSEQ keeps them steady through any wait states
  always_ff @(posedge HCLK) begin
    if (hTrans == HTRANS_NONSEQ) begin
      hwdataQ <= req.wdata;
      hwstrbQ <= req.mask;
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  // Holds the last read word until the next read completes
  always_ff @(posedge HCLK) begin
    if (captureEn) begin
      FetchBuffer <= HRDATA;
    end
  end

  // Gather the master side of the bus into one struct
  always_comb begin
    // The slave samples the address only while htrans is NONSEQ
    bus.haddr  = req.addr;
    bus.htrans = hTrans;
    bus.hwrite = hWrite;
    bus.hwdata = hwdataQ;
    bus.hwstrb = hwstrbQ;
  end

  ////////////////////
  // Control
  ////////////////////

  busFsm uBusFsm (
    .HCLK         (HCLK),
    .rstN         (rstN),
    .BusRW        (req.rw),
    .CPUBusy      (CPUBusy),
    .HREADY       (HREADY),
    .HTRANS       (hTrans),
    .HWRITE       (hWrite),
    .BusStall     (BusStall),
    .BusCommitted (BusCommitted),
    .CaptureEn    (captureEn)
  );

endmodule

/* hdl/ahbRam.sv */
// AHB-Lite RAM slave with address capture, wait-state counter and byte-masked array
`timescale 1ns/100ps
`include "bus_macros.svh"

module ahbRam import busPkg::*; (
  input  logic     HCLK,
  input  logic     rstN,
  input  ahbMaster bus,
  input  waitCount waitStates,
  output logic     HREADY,
  output xlenData  HRDATA
);

  // Word index width and number of byte lanes in a word
  localparam int WORD_W = $clog2(`RAM_WORDS);
  localparam int LANES  = `XLEN / 8;

  xlenData           mem [`RAM_WORDS];
  logic [WORD_W-1:0] wordAddr;
  logic              dataWrite;
  logic              dataActive;
  waitCount          waitLeft;
  logic              addrPhase;
  logic              lastCycle;

  ////////////////////
  // Handshake
  ////////////////////

  // A new transfer is only accepted while the bus is ready
  assign addrPhase = HREADY && (bus.htrans == HTRANS_NONSEQ);

  // The data phase finishes once the down-counter has run out
  assign lastCycle = dataActive && (waitLeft == '0);

  // Ready when no data phase is open or when it is in its final cycle
  assign HREADY = !dataActive || (waitLeft == '0);

  // Data phase tracking and the wait-state down-counter
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      dataActive <= 1'b0;
      waitLeft   <= '0;
    end else if (addrPhase) begin
      // Count is sampled here so later config writes leave this transfer alone
      dataActive <= 1'b1;
      waitLeft   <= waitStates;
    end else if (lastCycle) begin
      dataActive <= 1'b0;
    end else if (dataActive) begin
      waitLeft <= waitLeft - 1'b1;
    end
  end

  ////////////////////
  // Address capture
  ////////////////////

  // Word address and direction are held for the whole data phase
  // The two low address bits select a byte and the strobes cover that
  always_ff @(posedge HCLK) begin
    if (addrPhase) begin
      wordAddr  <= bus.haddr[WORD_W+1:2];
      dataWrite <= bus.hwrite;
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  // Writes land at the edge that ends the data phase
  // Only lanes with their strobe set are replaced and the rest keep old data
  always_ff @(posedge HCLK) begin
    if (lastCycle && dataWrite) begin
      for (int i = 0; i < LANES; i++) begin
        if (bus.hwstrb[i]) begin
          mem[wordAddr][8*i +: 8] <= bus.hwdata[8*i +: 8];
        end
      end
    end
  end

  // The addressed word is driven only in the final cycle of a read
  assign HRDATA = (lastCycle && !dataWrite) ? mem[wordAddr] : '0;

endmodule

/* hdl/busFsm.sv */
// Bus state machine that sequences address phase, data phase and CPU hold
`timescale 1ns/100ps

module busFsm import busPkg::*; (
  input  logic  HCLK,
  input  logic  rstN,
  input  busRw  BusRW,
  input  logic  CPUBusy,
  input  logic  HREADY,
  output htrans HTRANS,
  output logic  HWRITE,
  output logic  BusStall,
  output logic  BusCommitted,
  output logic  CaptureEn
);

  busState curState;
  busState nextState;
  logic    reqValid;
  logic    reqRead;
  logic    addrPhase;
  logic    dataDone;

  // Any nonzero request kind starts a transfer
  assign reqValid = (BusRW != RW_NONE);
  assign reqRead  = (BusRW == RW_READ);

  // The address phase is the idle cycle in which a request is present
  assign addrPhase = (curState == ADR_PHASE_IDLE) && reqValid;

  // The data phase ends at the first edge that sees HREADY high
  assign dataDone = (curState == DATA_PHASE) && HREADY;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      curState <= ADR_PHASE_IDLE;
    end else begin
      curState <= nextState;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    nextState = curState;
    case (curState)
      ADR_PHASE_IDLE: begin
        // Address goes out now, so the next cycle is the data phase
        if (reqValid) begin
          nextState = DATA_PHASE;
        end
      end
      DATA_PHASE: begin
        // A busy CPU cannot take the result yet, so hold off the next transfer
        if (HREADY) begin
          nextState = CPUBusy ? CPU_HOLD : ADR_PHASE_IDLE;
        end
      end
      CPU_HOLD: begin
        // No transfer starts here even if req already shows the next access
        if (!CPUBusy) begin
          nextState = ADR_PHASE_IDLE;
        end
      end
      default: begin
        nextState = ADR_PHASE_IDLE;
      end
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Only one transfer is in flight, so NONSEQ never overlaps a data phase
  assign HTRANS = addrPhase ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign HWRITE = addrPhase && (BusRW == RW_WRITE);

  // An access spans 2 + W cycles and the stall covers all of them but the last
  // The CPU sees the stall low at the edge that completes the transfer
  assign BusStall = addrPhase || ((curState == DATA_PHASE) && !HREADY);

  // Committed once the address has been accepted, and kept through CPU_HOLD
  assign BusCommitted = (curState != ADR_PHASE_IDLE);

  // Read data is valid on HRDATA in the final data-phase cycle
  assign CaptureEn = dataDone && reqRead;

endmodule

/* hdl/busPkg.sv */
// Vector typedefs, transfer and request encodings, FSM enum and request and bus structs
`include "bus_macros.svh"

package busPkg;

  ////////////////////
  // Vector types
  ////////////////////

  // One data word as carried on HWDATA, HRDATA and the fetch buffer
  typedef logic [`XLEN-1:0] xlenData;
  // One write enable bit per byte lane of a data word
  typedef logic [`XLEN/8-1:0] byteMask;
  typedef logic [`BUS_ADDR_W-1:0] busAddr;
  // Three bits cover every wait-state count up to seven
  typedef logic [2:0] waitCount;

  // Kind of access the load/store unit is asking for
  typedef logic [1:0] busRw;
  localparam busRw RW_NONE  = 2'b00;
  localparam busRw RW_WRITE = 2'b01;
  localparam busRw RW_READ  = 2'b10;

  // AHB transfer kind where only IDLE and NONSEQ are ever driven
  typedef logic [1:0] htrans;
  localparam htrans HTRANS_IDLE   = 2'b00;
  localparam htrans HTRANS_NONSEQ = 2'b10;

  // The idle state doubles as the address phase of a new transfer
  typedef enum logic [1:0] {ADR_PHASE_IDLE, DATA_PHASE, CPU_HOLD} busState;

  // Request as the CPU presents it and holds it while stalled
  typedef struct packed {
    busRw    rw;
    busAddr  addr;
    byteMask mask;
    xlenData wdata;
  } cpuReq;

  // Every signal the master drives toward the slave
  typedef struct packed {
    busAddr  haddr;
    htrans   htrans;
    logic    hwrite;
    xlenData hwdata;
    byteMask hwstrb;
  } ahbMaster;

endpackage

/* hdl/busTop.sv */
// Top level joining the CPU port, AHB-Lite master, wait-state config block and RAM slave
`timescale 1ns/100ps

module busTop import busPkg::*; (
  input  logic     HCLK,
  input  logic     rstN,
  input  cpuReq    req,
  input  logic     CPUBusy,
  input  logic     cfgWrite,
  input  waitCount cfgWaitStates,
  output logic     BusStall,
  output logic     BusCommitted,
  output xlenData  FetchBuffer,
  output waitCount cfgReadback
);

  // Master to slave signals travel together in one struct
  ahbMaster bus;
  logic     HREADY;
  xlenData  HRDATA;
  // Wait-state count that steers the RAM
  waitCount waitStates;

  ////////////////////
  // Master side
  ////////////////////

  ahbInterface uAhbInterface (
    .HCLK         (HCLK),
    .rstN         (rstN),
    .HREADY       (HREADY),
    .HRDATA       (HRDATA),
    .req          (req),
    .CPUBusy      (CPUBusy),
    .bus          (bus),
    .BusStall     (BusStall),
    .BusCommitted (BusCommitted),
    .FetchBuffer  (FetchBuffer)
  );

  ////////////////////
  // Slave side
  ////////////////////

  // Configuration registers sit beside the RAM they steer
  waitCfg uWaitCfg (
    .HCLK          (HCLK),
    .rstN          (rstN),
    .cfgWrite      (cfgWrite),
    .cfgWaitStates (cfgWaitStates),
    .waitStates    (waitStates),
    .cfgReadback   (cfgReadback)
  );

  ahbRam uAhbRam (
    .HCLK       (HCLK),
    .rstN       (rstN),
    .bus        (bus),
    .waitStates (waitStates),
    .HREADY     (HREADY),
    .HRDATA     (HRDATA)
  );

endmodule

/* hdl/bus_macros.svh */
// Data width, address width, RAM depth and wait-state ceiling defines for the bus path
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

////////////////////
// Data path widths
////////////////////

// Width of one data word on the CPU side and on the bus
`define XLEN 32

// Byte address width seen by the AHB-Lite slave
`define BUS_ADDR_W 12

////////////////////
// Slave sizing
////////////////////

// Number of words in the RAM behind the bus
`define RAM_WORDS 1024

// Largest number of wait states the configuration block will store
`define WAIT_MAX 7

`endif

/* hdl/waitCfg.sv */
// Wait-state configuration register with saturation and readback
`timescale 1ns/100ps
`include "bus_macros.svh"

module waitCfg import busPkg::*; (
  input  logic     HCLK,
  input  logic     rstN,
  input  logic     cfgWrite,
  input  waitCount cfgWaitStates,
  output waitCount waitStates,
  output waitCount cfgReadback
);

  // Ceiling taken from the build defines
  localparam waitCount WAIT_LIMIT = waitCount'(`WAIT_MAX);

  waitCount clampedValue;

  ////////////////////
  // Write side
  ////////////////////

  // Values above the ceiling are stored as the ceiling itself
  // With the default ceiling of seven every 3-bit value passes unchanged
  assign clampedValue = (cfgWaitStates > WAIT_LIMIT) ? WAIT_LIMIT : cfgWaitStates;

  // The new count applies from the edge after the write pulse
  // A transfer already past its address phase keeps the count it loaded
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      waitStates <= '0;
    end else if (cfgWrite) begin
      waitStates <= clampedValue;
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  // Readback shows the stored value after clamping
  assign cfgReadback = waitStates;

endmodule
